/* tb.f */
+incdir+.
cart_pkg.sv
mem_pkg.sv
cart_header_capture.sv
mbc1_bank_ctrl.sv
mem_request_mux.sv
cart_mapper_top.sv
tb_cart_mapper.sv

/* Bender.yml */
package:
  name: cart_mapper

sources:
  - files:
      - cart_pkg.sv
      - mem_pkg.sv
      - cart_header_capture.sv
      - mbc1_bank_ctrl.sv
      - mem_request_mux.sv
      - cart_mapper_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cart_mapper.sv

/* tb_cart_mapper_tasks.svh */
// cartridge mapper testbench helpers: compares, bus drivers, lfsr and directed tests
`ifndef tb_cart_mapper_tasks_svh
`define tb_cart_mapper_tasks_svh

// ----------------------------------------------------------------------
// typed compares, x counts as a mismatch
// ----------------------------------------------------------------------

task automatic check_addr(input string name, input logic [mem_pkg::mem_addr_w-1:0] got,
	input logic [mem_pkg::mem_addr_w-1:0] exp);
	if (got !== exp) begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end_with_failure();
	end
endtask

task automatic check_word(input string name, input logic [mem_pkg::mem_data_w-1:0] got,
	input logic [mem_pkg::mem_data_w-1:0] exp);
	if (got !== exp) begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end_with_failure();
	end
endtask

task automatic check_byte(input string name, input logic [cart_pkg::cart_data_w-1:0] got,
	input logic [cart_pkg::cart_data_w-1:0] exp);
	if (got !== exp) begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		end_with_failure();
	end
endtask

task automatic check_lanes(input string name, input logic [mem_pkg::lane_w-1:0] got,
	input logic [mem_pkg::lane_w-1:0] exp);
	if (got !== exp) begin
		$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		end_with_failure();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		end_with_failure();
	end
endtask

// ----------------------------------------------------------------------
// patterns and expected values
// ----------------------------------------------------------------------

// taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

// one step per bit taken
function automatic logic [mem_pkg::mem_data_w-1:0] random_word();
	logic [mem_pkg::mem_data_w-1:0] w;
	w = '0;
	for (int i = 0; i < mem_pkg::mem_data_w; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		w = {w[mem_pkg::mem_data_w-2:0], lfsr_state[0]};
	end
	return w;
endfunction

// 3 zero bits, bank, byte offset over two
function automatic logic [mem_pkg::mem_addr_w-1:0] cpu_word_addr(
	input logic [cart_pkg::bank_w-1:0] bank, input logic [cart_pkg::cart_addr_w-1:0] addr);
	return {3'b000, bank, addr[12:1]};
endfunction

// even byte on the high lane
function automatic logic [mem_pkg::lane_w-1:0] byte_lanes(
	input logic [cart_pkg::cart_addr_w-1:0] addr);
	return addr[0] ? 2'b01 : 2'b10;
endfunction

// switchable window: masked rom bank times two plus address bit 13
function automatic logic [cart_pkg::bank_w-1:0] switch_bank(input logic [6:0] rom_bank,
	input logic [6:0] mask, input logic half);
	logic [cart_pkg::bank_w-1:0] eff;
	eff = {2'b00, rom_bank & mask};
	return eff * 9'd2 + {8'd0, half};
endfunction

// ----------------------------------------------------------------------
// bus drivers, inputs change on the falling edge
// ----------------------------------------------------------------------

// dl_active stays high until end_download
task automatic download_word(input logic [mem_pkg::mem_addr_w-1:0] addr,
	input logic [mem_pkg::mem_data_w-1:0] data);
	@(negedge clk4);
	dl_active = 1'b1;
	dl_write  = 1'b1;
	dl_addr   = addr;
	dl_data   = data;
	#1;
	check_addr("mem_addr", mem_addr, addr);
	check_word("mem_wdata", mem_wdata, data);
	// both lanes
	check_lanes("mem_lanes", mem_lanes, 2'b11);
	check_bit("mem_we", mem_we, 1'b1);
	check_bit("mem_oe", mem_oe, 1'b0);
	@(negedge clk4);
	dl_write = 1'b0;
endtask

task automatic end_download();
	@(negedge clk4);
	dl_active = 1'b0;
	dl_addr   = '0;
	dl_data   = '0;
endtask

// type byte at 0x147, sizes at 0x148/0x149
task automatic load_header(input logic [7:0] mbc_type, input logic [7:0] rom_code,
	input logic [7:0] ram_code);
	download_word(24'h0000a3, {8'h00, mbc_type});
	download_word(24'h0000a4, {rom_code, ram_code});
	end_download();
endtask

// hands back the memory request seen during the strobe
task automatic cpu_write(input logic [cart_pkg::cart_addr_w-1:0] addr,
	input logic [cart_pkg::cart_data_w-1:0] data, output logic we_seen,
	output logic [mem_pkg::mem_addr_w-1:0] addr_seen,
	output logic [mem_pkg::lane_w-1:0] lanes_seen);
	@(negedge clk4);
	cart_addr  = addr;
	cart_wdata = data;
	cart_wr    = 1'b1;
	#1;
	we_seen    = mem_we;
	addr_seen  = mem_addr;
	lanes_seen = mem_lanes;
	check_bit("mem_oe", mem_oe, 1'b0);
	if (mem_we)
		check_word("mem_wdata", mem_wdata, {data, data});
	@(negedge clk4);
	cart_wr = 1'b0;
endtask

// register writes never reach memory
task automatic cpu_reg_write(input logic [cart_pkg::cart_addr_w-1:0] addr,
	input logic [cart_pkg::cart_data_w-1:0] data);
	logic                           we;
	logic [mem_pkg::mem_addr_w-1:0] wa;
	logic [mem_pkg::lane_w-1:0]     wl;
	cpu_write(addr, data, we, wa, wl);
	check_bit("mem_we", we, 1'b0);
endtask

task automatic cpu_read(input logic [cart_pkg::cart_addr_w-1:0] addr,
	output logic [cart_pkg::cart_data_w-1:0] data,
	output logic [mem_pkg::mem_addr_w-1:0] addr_seen,
	output logic [mem_pkg::lane_w-1:0] lanes_seen);
	@(negedge clk4);
	cart_addr = addr;
	cart_rd   = 1'b1;
	#1;
	data       = cart_rdata;
	addr_seen  = mem_addr;
	lanes_seen = mem_lanes;
	check_bit("mem_oe", mem_oe, 1'b1);
	check_bit("mem_we", mem_we, 1'b0);
	@(negedge clk4);
	cart_rd = 1'b0;
endtask

// read and compare the word address and lanes only
task automatic read_check_bank(input logic [cart_pkg::cart_addr_w-1:0] addr,
	input logic [cart_pkg::bank_w-1:0] exp_bank);
	logic [cart_pkg::cart_data_w-1:0] rd;
	logic [mem_pkg::mem_addr_w-1:0]   ra;
	logic [mem_pkg::lane_w-1:0]       rl;
	cpu_read(addr, rd, ra, rl);
	check_addr("mem_addr", ra, cpu_word_addr(exp_bank, addr));
	check_lanes("mem_lanes", rl, byte_lanes(addr));
endtask

// ----------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------

task automatic test_download_pass_through();
	logic [mem_pkg::mem_addr_w-1:0]   words [4];
	logic [mem_pkg::mem_data_w-1:0]   data [4];
	logic [cart_pkg::cart_data_w-1:0] rd;
	logic [mem_pkg::mem_addr_w-1:0]   ra;
	logic [mem_pkg::lane_w-1:0]       rl;
	logic [cart_pkg::cart_addr_w-1:0] byte_addr;
	$display("test: download pass-through");
	// idle port after reset
	check_bit("mem_we", mem_we, 1'b0);
	check_bit("mem_oe", mem_oe, 1'b0);
	words = '{24'h000200, 24'h000201, 24'h001234, 24'h003fff};
	for (int i = 0; i < 4; i++) begin
		data[i] = random_word();
		download_word(words[i], data[i]);
	end
	end_download();
	// header still zero, linear 32k, byte address twice the word address
	for (int i = 0; i < 4; i++) begin
		byte_addr = {words[i][14:0], 1'b0};
		cpu_read(byte_addr, rd, ra, rl);
		check_addr("mem_addr", ra, words[i]);
		check_lanes("mem_lanes", rl, 2'b10);
		check_byte("cart_rdata", rd, data[i][15:8]);
		cpu_read(byte_addr | 16'h0001, rd, ra, rl);
		check_addr("mem_addr", ra, words[i]);
		check_lanes("mem_lanes", rl, 2'b01);
		check_byte("cart_rdata", rd, data[i][7:0]);
	end
endtask

task automatic test_no_mbc();
	$display("test: no mbc");
	load_header(8'h00, 8'h00, 8'h00);
	read_check_bank(16'h6000, 9'd3);
	read_check_bank(16'h4001, 9'd2);
	read_check_bank(16'h1fff, 9'd0);
	// bank register ignored by the linear map
	cpu_reg_write(16'h2000, 8'h05);
	read_check_bank(16'h4000, 9'd2);
endtask

task automatic test_mbc1_rom_banking();
	logic [6:0] mask;
	$display("test: mbc1 rom banking");
	load_header(8'h01, 8'h02, 8'h00);
	// size code 2, eight 16k banks
	mask = 7'h07;
	cpu_reg_write(16'h6000, 8'h00);
	cpu_reg_write(16'h4000, 8'h00);
	cpu_reg_write(16'h2000, 8'h00);
	// zero becomes bank 1
	read_check_bank(16'h4000, switch_bank(7'd1, mask, 1'b0));
	read_check_bank(16'h6000, switch_bank(7'd1, mask, 1'b1));
	cpu_reg_write(16'h2000, 8'd13);
	read_check_bank(16'h4000, switch_bank(7'd13, mask, 1'b0));
	read_check_bank(16'h7ffe, switch_bank(7'd13, mask, 1'b1));
	// fixed window unaffected
	read_check_bank(16'h0000, 9'd0);
	read_check_bank(16'h3fff, 9'd1);
	// only five bits kept, 0x33 gives 0x13
	cpu_reg_write(16'h2000, 8'h33);
	read_check_bank(16'h5000, switch_bank(7'h13, mask, 1'b0));
	// 0x20 has zero low bits, so bank 1 again
	cpu_reg_write(16'h2000, 8'h20);
	read_check_bank(16'h4000, switch_bank(7'd1, mask, 1'b0));
endtask

task automatic test_ram_enable_banking();
	logic [mem_pkg::mem_data_w-1:0]   pat;
	logic                             we;
	logic [mem_pkg::mem_addr_w-1:0]   wa;
	logic [mem_pkg::lane_w-1:0]       wl;
	logic [cart_pkg::cart_data_w-1:0] rd;
	$display("test: ram enable and banking");
	load_header(8'h03, 8'h02, 8'h03);
	pat = random_word();
	cpu_reg_write(16'h0000, 8'h00);
	cpu_write(16'ha000, pat[15:8], we, wa, wl);
	check_bit("mem_we", we, 1'b0);
	// key in the low nibble, high nibble ignored
	cpu_reg_write(16'h1fff, 8'h5a);
	cpu_reg_write(16'h6000, 8'h01);
	cpu_reg_write(16'h4000, 8'h02);
	// both bytes of one word, ram bank 2 above rom
	cpu_write(16'ha122, pat[15:8], we, wa, wl);
	check_bit("mem_we", we, 1'b1);
	check_addr("mem_addr", wa, cpu_word_addr(9'd256 + 9'd2, 16'ha122));
	check_lanes("mem_lanes", wl, 2'b10);
	cpu_write(16'ha123, pat[7:0], we, wa, wl);
	check_bit("mem_we", we, 1'b1);
	check_addr("mem_addr", wa, cpu_word_addr(9'd256 + 9'd2, 16'ha123));
	check_lanes("mem_lanes", wl, 2'b01);
	// lanes kept each byte apart
	cpu_read(16'ha122, rd, wa, wl);
	check_byte("cart_rdata", rd, pat[15:8]);
	cpu_read(16'ha123, rd, wa, wl);
	check_byte("cart_rdata", rd, pat[7:0]);
	// mode 0 pins ram to bank 0
	cpu_reg_write(16'h6000, 8'h00);
	read_check_bank(16'hbffe, 9'd256);
	// key removed, writes blocked again
	cpu_reg_write(16'h0000, 8'h00);
	cpu_write(16'hb000, pat[7:0], we, wa, wl);
	check_bit("mem_we", we, 1'b0);
endtask

task automatic test_force_input();
	$display("test: force mbc1");
	// type 0, size code 5, 64 banks
	load_header(8'h00, 8'h05, 8'h00);
	@(negedge clk4);
	force_mbc1 = 1'b1;
	cpu_reg_write(16'h6000, 8'h00);
	cpu_reg_write(16'h4000, 8'h00);
	cpu_reg_write(16'h2000, 8'h09);
	read_check_bank(16'h4000, switch_bank(7'd9, 7'h3f, 1'b0));
	read_check_bank(16'h2000, 9'd1);
	@(negedge clk4);
	force_mbc1 = 1'b0;
	// back to linear 32k
	read_check_bank(16'h4000, 9'd2);
	read_check_bank(16'h6000, 9'd3);
	read_check_bank(16'ha000, 9'd1);
endtask

`endif

/* tb_cart_mapper.sv */
// cartridge mapper testbench: clock, reset, word memory model, timeout and test order
module tb_cart_mapper;

	timeunit 1ns;
	timeprecision 1ps;

	// ----------------------------------------------------------------------
	// run limits
	// ----------------------------------------------------------------------

	localparam int reset_cycles    = 8;
	localparam int num_tests       = 5;
	// longest test stays well below this
	localparam int cycles_per_test = 200;
	// double the summed budget, 2000 cycles
	localparam int timeout_cycles  = 2 * num_tests * cycles_per_test;

	// model covers 2 MiB words, rom plus cart ram above it
	localparam int model_aw = 21;

	logic                                clk4;
	logic                                reset;
	logic                                force_mbc1;

	// download port
	logic                                dl_active;
	logic                                dl_write;
	logic [mem_pkg::mem_addr_w-1:0]      dl_addr;
	logic [mem_pkg::mem_data_w-1:0]      dl_data;

	// cpu slot
	logic [cart_pkg::cart_addr_w-1:0]    cart_addr;
	logic                                cart_rd;
	logic                                cart_wr;
	logic [cart_pkg::cart_data_w-1:0]    cart_wdata;
	logic [cart_pkg::cart_data_w-1:0]    cart_rdata;

	// memory port
	logic [mem_pkg::mem_addr_w-1:0]      mem_addr;
	logic [mem_pkg::mem_data_w-1:0]      mem_wdata;
	logic [mem_pkg::lane_w-1:0]          mem_lanes;
	logic                                mem_we;
	logic                                mem_oe;
	logic [mem_pkg::mem_data_w-1:0]      mem_rdata;

	// pattern source
	logic [31:0]                         lfsr_state;
	int                                  cycle_count = 0;

	// memory model, one byte array per lane
	logic [cart_pkg::cart_data_w-1:0]    mem_hi [0:(1<<model_aw)-1];
	logic [cart_pkg::cart_data_w-1:0]    mem_lo [0:(1<<model_aw)-1];

	cart_mapper_top cart_mapper_top_i (
		.clk4       (clk4),
		.reset      (reset),
		.force_mbc1 (force_mbc1),
		.dl_active  (dl_active),
		.dl_write   (dl_write),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.cart_wdata (cart_wdata),
		.cart_rdata (cart_rdata),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_lanes  (mem_lanes),
		.mem_we     (mem_we),
		.mem_oe     (mem_oe),
		.mem_rdata  (mem_rdata)
	);

	// ----------------------------------------------------------------------
	// clock, memory model, cycle limit
	// ----------------------------------------------------------------------

	initial begin
		clk4 = 1'b0;
		forever #5 clk4 = ~clk4;
	end

	// read answers in the same cycle
	assign mem_rdata = {mem_hi[mem_addr[model_aw-1:0]], mem_lo[mem_addr[model_aw-1:0]]};

	// lane 1 high byte, lane 0 low byte
	always @(posedge clk4) begin
		if (mem_we) begin
			if (mem_addr[mem_pkg::mem_addr_w-1:model_aw] != '0) begin
				$display("memory write above the modelled 2 MiB word range");
				end_with_failure();
			end
			if (mem_lanes[1])
				mem_hi[mem_addr[model_aw-1:0]] <= mem_wdata[15:8];
			if (mem_lanes[0])
				mem_lo[mem_addr[model_aw-1:0]] <= mem_wdata[7:0];
		end
	end

	always @(posedge clk4) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: tests still running after %0d cycles", cycle_count);
			end_with_failure();
		end
	end

	task automatic end_with_failure();
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first failure");
	endtask

	`include "tb_cart_mapper_tasks.svh"

	// ----------------------------------------------------------------------
	// sequence
	// ----------------------------------------------------------------------

	initial begin
		reset      = 1'b1;
		force_mbc1 = 1'b0;
		dl_active  = 1'b0;
		dl_write   = 1'b0;
		dl_addr    = '0;
		dl_data    = '0;
		cart_addr  = '0;
		cart_rd    = 1'b0;
		cart_wr    = 1'b0;
		cart_wdata = '0;
		lfsr_state = 32'ha7f0;
		repeat (reset_cycles) @(posedge clk4);
		@(negedge clk4);
		reset = 1'b0;
		test_download_pass_through();
		test_no_mbc();
		test_mbc1_rom_banking();
		test_ram_enable_banking();
		test_force_input();
		repeat (2) @(negedge clk4);
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* cart_mapper_top.sv */
// cartridge mapper top: header capture, mbc1 bank controller and memory request mux
module cart_mapper_top (
	input  logic                               clk4,
	input  logic                               reset,
	input  logic                               force_mbc1,

	// rom download
	input  logic                               dl_active,
	input  logic                               dl_write,
	input  logic [mem_pkg::mem_addr_w-1:0]     dl_addr,
	input  logic [mem_pkg::mem_data_w-1:0]     dl_data,

	// cpu cartridge slot
	input  logic [cart_pkg::cart_addr_w-1:0]   cart_addr,
	input  logic                               cart_rd,
	input  logic                               cart_wr,
	input  logic [cart_pkg::cart_data_w-1:0]   cart_wdata,
	output logic [cart_pkg::cart_data_w-1:0]   cart_rdata,

	// external memory
	output logic [mem_pkg::mem_addr_w-1:0]     mem_addr,
	output logic [mem_pkg::mem_data_w-1:0]     mem_wdata,
	output logic [mem_pkg::lane_w-1:0]         mem_lanes,
	output logic                               mem_we,
	output logic                               mem_oe,
	input  logic [mem_pkg::mem_data_w-1:0]     mem_rdata
);

	// header decode to bank controller
	logic [cart_pkg::rom_bank_w-1:0] rom_mask;
	logic [cart_pkg::ram_bank_w-1:0] ram_mask;
	logic                            mbc1_present;

	// bank controller to mux
	logic [cart_pkg::bank_w-1:0]     bank;
	logic                            cart_ram_wr;

	// ----------------------------------------------------------------------
	// header capture
	// ----------------------------------------------------------------------

	cart_header_capture cart_header_capture_i (
		.clk4         (clk4),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_write     (dl_write),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.force_mbc1   (force_mbc1),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.mbc1_present (mbc1_present)
	);

	// ----------------------------------------------------------------------
	// mbc1 registers and bank number
	// ----------------------------------------------------------------------

	mbc1_bank_ctrl mbc1_bank_ctrl_i (
		.clk4         (clk4),
		.reset        (reset),
		.cart_addr    (cart_addr),
		.cart_wr      (cart_wr),
		.cart_wdata   (cart_wdata),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.mbc1_present (mbc1_present),
		.bank         (bank),
		.cart_ram_wr  (cart_ram_wr)
	);

	// ----------------------------------------------------------------------
	// memory port
	// ----------------------------------------------------------------------

	mem_request_mux mem_request_mux_i (
		.dl_active   (dl_active),
		.dl_write    (dl_write),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.cart_addr   (cart_addr),
		.cart_rd     (cart_rd),
		.cart_wdata  (cart_wdata),
		.bank        (bank),
		.cart_ram_wr (cart_ram_wr),
		.mem_rdata   (mem_rdata),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_lanes   (mem_lanes),
		.mem_we      (mem_we),
		.mem_oe      (mem_oe),
		.cart_rdata  (cart_rdata)
	);

endmodule

/* mem_request_mux.sv */
// memory request mux: download or cpu onto one word port, lanes and read byte select
module mem_request_mux (
	input  logic                               dl_active,
	input  logic                               dl_write,
	input  logic [mem_pkg::mem_addr_w-1:0]     dl_addr,
	input  logic [mem_pkg::mem_data_w-1:0]     dl_data,
	input  logic [cart_pkg::cart_addr_w-1:0]   cart_addr,
	input  logic                               cart_rd,
	input  logic [cart_pkg::cart_data_w-1:0]   cart_wdata,
	input  logic [cart_pkg::bank_w-1:0]        bank,
	input  logic                               cart_ram_wr,
	input  logic [mem_pkg::mem_data_w-1:0]     mem_rdata,
	output logic [mem_pkg::mem_addr_w-1:0]     mem_addr,
	output logic [mem_pkg::mem_data_w-1:0]     mem_wdata,
	output logic [mem_pkg::lane_w-1:0]         mem_lanes,
	output logic                               mem_we,
	output logic                               mem_oe,
	output logic [cart_pkg::cart_data_w-1:0]   cart_rdata
);

	// cpu side request
	logic [mem_pkg::mem_addr_w-1:0] cpu_addr;
	logic [mem_pkg::lane_w-1:0]     cpu_lanes;
	// odd cart byte sits in the low half
	logic                           odd_byte;

	assign odd_byte = cart_addr[0];

	// pad, bank, word offset inside the 8k bank
	assign cpu_addr = {{mem_pkg::cpu_addr_pad_w{1'b0}}, bank,
		cart_addr[mem_pkg::cpu_offset_w:1]};

	assign cpu_lanes = odd_byte ? mem_pkg::lanes_low : mem_pkg::lanes_high;

	// ----------------------------------------------------------------------
	// request select, download owns the port
	// ----------------------------------------------------------------------

	always_comb begin
		if (dl_active) begin
			mem_addr  = dl_addr;
			mem_wdata = dl_data;
			mem_lanes = mem_pkg::lanes_both;
			mem_we    = dl_write;
			mem_oe    = 1'b0;
		end else begin
			mem_addr  = cpu_addr;
			// same byte on both halves, lanes pick one
			mem_wdata = {cart_wdata, cart_wdata};
			mem_lanes = cpu_lanes;
			mem_we    = cart_ram_wr;
			mem_oe    = cart_rd;
		end
	end

	// ----------------------------------------------------------------------
	// read byte
	// ----------------------------------------------------------------------

	assign cart_rdata = odd_byte ? mem_rdata[mem_pkg::byte_w-1:0] :
		mem_rdata[mem_pkg::mem_data_w-1 -: mem_pkg::byte_w];

	// cpu read and cart ram write never overlap
	always_comb begin
		we_oe_exclusive: assert final (!(mem_we && mem_oe))
			else $error("mem_we and mem_oe both high");
	end

endmodule

/* mbc1_bank_ctrl.sv */
// mbc1 bank controller: cpu-written bank registers, 8k bank number and ram write permission
module mbc1_bank_ctrl (
	input  logic                               clk4,
	input  logic                               reset,
	input  logic [cart_pkg::cart_addr_w-1:0]   cart_addr,
	input  logic                               cart_wr,
	input  logic [cart_pkg::cart_data_w-1:0]   cart_wdata,
	input  logic [cart_pkg::rom_bank_w-1:0]    rom_mask,
	input  logic [cart_pkg::ram_bank_w-1:0]    ram_mask,
	input  logic                               mbc1_present,
	output logic [cart_pkg::bank_w-1:0]        bank,
	output logic                               cart_ram_wr
);

	// bit 13 picks the 8k half of a 16k rom bank
	localparam int half_bit = cart_pkg::cart_addr_w - cart_pkg::region_w;

	logic [cart_pkg::region_w-1:0]       region;
	logic [cart_pkg::quad_w-1:0]         quad;

	// mbc1 registers
	logic                                ram_enable;
	logic                                mode;
	logic [cart_pkg::rom_bank_reg_w-1:0] rom_bank_reg;
	logic [cart_pkg::ram_bank_w-1:0]     ram_bank_reg;

	// effective banks after mode and mask
	logic [cart_pkg::ram_bank_w-1:0]     rom_upper;
	logic [cart_pkg::rom_bank_w-1:0]     rom_bank_eff;
	logic [cart_pkg::ram_bank_w-1:0]     ram_bank_eff;

	logic [cart_pkg::bank_w-1:0]         mbc1_bank;
	logic [cart_pkg::bank_w-1:0]         linear_bank;

	assign region = cart_addr[cart_pkg::cart_addr_w-1 -: cart_pkg::region_w];
	assign quad   = cart_addr[cart_pkg::cart_addr_w-1 -: cart_pkg::quad_w];

	// ----------------------------------------------------------------------
	// register writes, cpu writes into rom space
	// ----------------------------------------------------------------------

	always_ff @(posedge clk4) begin
		if (reset) begin
			ram_enable   <= cart_pkg::ram_enable_reset;
			mode         <= cart_pkg::mode_reset;
			rom_bank_reg <= cart_pkg::rom_bank_reg_reset;
			ram_bank_reg <= cart_pkg::ram_bank_reg_reset;
		end else if (cart_wr) begin
			case (region)
				// 0x0000..0x1fff
				cart_pkg::region_ram_enable:
					ram_enable <= (cart_wdata[cart_pkg::ram_key_w-1:0] ==
						cart_pkg::ram_enable_key);
				// 0x2000..0x3fff, bank 0 not selectable here
				cart_pkg::region_rom_bank: begin
					if (cart_wdata[cart_pkg::rom_bank_reg_w-1:0] == '0)
						rom_bank_reg <= cart_pkg::rom_bank_reg_min;
					else
						rom_bank_reg <= cart_wdata[cart_pkg::rom_bank_reg_w-1:0];
				end
				// 0x4000..0x5fff, ram bank or rom bits 6..5
				cart_pkg::region_ram_bank:
					ram_bank_reg <= cart_wdata[cart_pkg::ram_bank_w-1:0];
				// 0x6000..0x7fff
				cart_pkg::region_mode:
					mode <= cart_wdata[0];
				default: begin
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// effective banks
	// ----------------------------------------------------------------------

	// mode 0: ram bank register drives upper rom bits
	assign rom_upper    = mode ? '0 : ram_bank_reg;
	assign rom_bank_eff = {rom_upper, rom_bank_reg} & rom_mask;

	// mode 1: four ram banks
	assign ram_bank_eff = (mode ? ram_bank_reg : '0) & ram_mask;

	// ----------------------------------------------------------------------
	// bank number
	// ----------------------------------------------------------------------

	always_comb begin
		mbc1_bank = '0;
		if (quad == cart_pkg::quad_rom_fixed) begin
			// 16k rom bank 0
			mbc1_bank = {{(cart_pkg::bank_w-1){1'b0}}, cart_addr[half_bit]};
		end else if (quad == cart_pkg::quad_rom_switch) begin
			// switchable 16k bank
			mbc1_bank = {1'b0, rom_bank_eff, cart_addr[half_bit]};
		end else if (region == cart_pkg::region_cart_ram) begin
			// 8k ram banks above rom
			mbc1_bank = cart_pkg::ram_bank_reg_base |
				{{(cart_pkg::bank_w-cart_pkg::ram_bank_w){1'b0}}, ram_bank_eff};
		end
	end

	// plain 32k cart, bits 14..13 straight through
	assign linear_bank = {{(cart_pkg::bank_w-2){1'b0}}, cart_addr[half_bit+1:half_bit]};

	assign bank = mbc1_present ? mbc1_bank : linear_bank;

	// ram writes need the enable key first
	assign cart_ram_wr = cart_wr && ram_enable && (region == cart_pkg::region_cart_ram);

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------

	// zero write rule keeps bank 0 out of the switchable window
	rom_bank_reg_nonzero: assert property (@(posedge clk4) disable iff (reset)
		rom_bank_reg != '0);

	// ram area bit only in the cart ram window
	ram_bit_only_in_ram_region: assert property (@(posedge clk4) disable iff (reset)
		bank[cart_pkg::bank_w-1] |-> (region == cart_pkg::region_cart_ram));

endmodule

/* cart_header_capture.sv */
// cartridge header capture: snoops rom download, keeps type and size codes, decodes masks
module cart_header_capture (
	input  logic                               clk4,
	input  logic                               reset,
	input  logic                               dl_active,
	input  logic                               dl_write,
	input  logic [mem_pkg::mem_addr_w-1:0]     dl_addr,
	input  mem_pkg::header_word_u              dl_data,
	input  logic                               force_mbc1,
	output logic [cart_pkg::rom_bank_w-1:0]    rom_mask,
	output logic [cart_pkg::ram_bank_w-1:0]    ram_mask,
	output logic                               mbc1_present
);

	// header bytes as seen in the image
	logic [cart_pkg::hdr_code_w-1:0] mbc_type;
	logic [cart_pkg::hdr_code_w-1:0] rom_size;
	logic [cart_pkg::hdr_code_w-1:0] ram_size;
	// download write strobe
	logic                            hdr_wr;

	assign hdr_wr = dl_active && dl_write;

	// ----------------------------------------------------------------------
	// capture
	// ----------------------------------------------------------------------

	always_ff @(posedge clk4) begin
		if (reset) begin
			mbc_type <= '0;
			rom_size <= '0;
			ram_size <= '0;
		end else if (hdr_wr) begin
			// type byte is odd, so low half of the word
			if (dl_addr == mem_pkg::hdr_mbc_type_word)
				mbc_type <= dl_data.raw[mem_pkg::byte_w-1:0];
			if (dl_addr == mem_pkg::hdr_size_word) begin
				rom_size <= dl_data.sizes.rom_size;
				ram_size <= dl_data.sizes.ram_size;
			end
		end
	end

	// ----------------------------------------------------------------------
	// decode
	// ----------------------------------------------------------------------

	// rom mask keeps bank numbers inside the image, mirrors above it
	always_comb begin
		case (rom_size)
			cart_pkg::rom_size_code_52: rom_mask = cart_pkg::rom_mask_code_52;
			cart_pkg::rom_size_code_53: rom_mask = cart_pkg::rom_mask_code_53;
			default: begin
				if (rom_size <= cart_pkg::rom_size_last)
					rom_mask = cart_pkg::rom_mask_by_size[rom_size[cart_pkg::rom_size_idx_w-1:0]];
				else
					rom_mask = cart_pkg::rom_mask_default;
			end
		endcase
	end

	// no ram, 2k or 8k: single bank
	assign ram_mask = (ram_size <= cart_pkg::ram_size_code_8k) ?
		cart_pkg::ram_mask_single : cart_pkg::ram_mask_four;

	// header says mbc1, or forced from outside
	assign mbc1_present = ((mbc_type >= cart_pkg::mbc_type_mbc1_first) &&
		(mbc_type <= cart_pkg::mbc_type_mbc1_last)) || force_mbc1;

	// header only moves while an image is coming in
	hdr_stable_outside_dl: assert property (@(posedge clk4) disable iff (reset)
		!dl_active |=> $stable({mbc_type, rom_size, ram_size}));

endmodule

/* mem_pkg.sv */
// memory package: word port widths, byte lanes, header word offsets and header word view
package mem_pkg;

	// ----------------------------------------------------------------------
	// 16-bit external memory, word addressed
	// ----------------------------------------------------------------------

	localparam int mem_addr_w = 24;
	localparam int mem_data_w = 16;
	localparam int byte_w     = 8;

	// lane bit 1 is the high byte, lane bit 0 the low byte
	localparam int lane_w = 2;
	localparam logic [lane_w-1:0] lanes_both = 2'b11;
	// even cart address sits in the high byte
	localparam logic [lane_w-1:0] lanes_high = 2'b10;
	localparam logic [lane_w-1:0] lanes_low  = 2'b01;

	// cpu word address layout: pad, bank, offset inside an 8k bank
	localparam int cpu_addr_pad_w = 3;
	localparam int cpu_offset_w   = 12;

	// ----------------------------------------------------------------------
	// header words, byte address shifted right by one
	// ----------------------------------------------------------------------

	// 0x146/0x147, type in the low byte
	localparam logic [mem_addr_w-1:0] hdr_mbc_type_word = 24'h0000a3;
	// 0x148/0x149, rom size high, ram size low
	localparam logic [mem_addr_w-1:0] hdr_size_word     = 24'h0000a4;

	// one download word, plain or split into the two size codes
	typedef union packed {
		logic [mem_data_w-1:0] raw;
		struct packed {
			logic [byte_w-1:0] rom_size;
			logic [byte_w-1:0] ram_size;
		} sizes;
	} header_word_u;

endpackage

/* cart_pkg.sv */
// cartridge package: MBC1 register map, header codes, bank widths and reset values
package cart_pkg;

	// ----------------------------------------------------------------------
	// cpu side of the cartridge slot
	// ----------------------------------------------------------------------

	localparam int cart_addr_w = 16;
	localparam int cart_data_w = 8;

	// address bits 15..13 pick the register or memory region
	localparam int region_w = 3;
	// address bits 15..14 pick fixed or switchable rom
	localparam int quad_w = 2;

	localparam logic [region_w-1:0] region_ram_enable = 3'd0;
	localparam logic [region_w-1:0] region_rom_bank   = 3'd1;
	localparam logic [region_w-1:0] region_ram_bank   = 3'd2;
	localparam logic [region_w-1:0] region_mode       = 3'd3;
	// 0xa000..0xbfff, external cart ram
	localparam logic [region_w-1:0] region_cart_ram   = 3'd5;

	localparam logic [quad_w-1:0] quad_rom_fixed  = 2'd0;
	localparam logic [quad_w-1:0] quad_rom_switch = 2'd1;

	// ----------------------------------------------------------------------
	// bank numbers, 8 KiB units in memory
	// ----------------------------------------------------------------------

	localparam int bank_w         = 9;
	localparam int rom_bank_w     = 7;
	localparam int rom_bank_reg_w = 5;
	localparam int ram_bank_w     = 2;

	// top bank bit set, cart ram lives above 2 MiB of rom
	localparam logic [bank_w-1:0] ram_bank_reg_base = 9'h100;

	// ram enable: low nibble must match
	localparam int ram_key_w = 4;
	localparam logic [ram_key_w-1:0] ram_enable_key = 4'ha;

	// register state after reset
	localparam logic [rom_bank_reg_w-1:0] rom_bank_reg_min   = 5'd1;
	localparam logic [rom_bank_reg_w-1:0] rom_bank_reg_reset = rom_bank_reg_min;
	localparam logic [ram_bank_w-1:0]     ram_bank_reg_reset = 2'd0;
	localparam logic                      mode_reset         = 1'b0;
	localparam logic                      ram_enable_reset   = 1'b0;

	// ----------------------------------------------------------------------
	// cartridge header codes
	// ----------------------------------------------------------------------

	localparam int hdr_code_w = 8;

	// mbc1, mbc1+ram, mbc1+ram+battery
	localparam logic [hdr_code_w-1:0] mbc_type_mbc1_first = 8'h01;
	localparam logic [hdr_code_w-1:0] mbc_type_mbc1_last  = 8'h03;

	// rom size codes 0..6 are powers of two
	localparam int rom_size_idx_w = 3;
	localparam logic [hdr_code_w-1:0] rom_size_last    = 8'h06;
	localparam logic [hdr_code_w-1:0] rom_size_code_52 = 8'h52;
	localparam logic [hdr_code_w-1:0] rom_size_code_53 = 8'h53;

	// 32k direct, then 64k up to 2M
	localparam logic [rom_bank_w-1:0] rom_mask_by_size [0:6] = '{
		7'h00, 7'h03, 7'h07, 7'h0f, 7'h1f, 7'h3f, 7'h7f
	};
	// 72 banks, 80 banks, everything else taken as 96 banks
	localparam logic [rom_bank_w-1:0] rom_mask_code_52 = 7'h47;
	localparam logic [rom_bank_w-1:0] rom_mask_code_53 = 7'h4f;
	localparam logic [rom_bank_w-1:0] rom_mask_default = 7'h5f;

	// ram size codes up to 8k use one bank
	localparam logic [hdr_code_w-1:0] ram_size_code_8k = 8'h02;
	localparam logic [ram_bank_w-1:0] ram_mask_single  = 2'b00;
	localparam logic [ram_bank_w-1:0] ram_mask_four    = 2'b11;

endpackage
